// ==== logic/serial_link_pkg.sv ====
// Dimensions and frame format of the serial link.
// RTL and testbench refer to these definitions by scoped names.

`default_nettype none

package serial_link_pkg;

  // Link dimensions
  localparam int unsigned NumLanes      = 4;
  localparam int unsigned NarrowWidth   = 16;
  localparam int unsigned WideWidth     = 32;
  localparam int unsigned FrameHdrWidth = 4;
  localparam int unsigned FrameWidth    = FrameHdrWidth + WideWidth;
  localparam int unsigned BeatsPerFrame = FrameWidth / NumLanes;

  // Beat timing of the physical layer
  localparam int unsigned MaxClkDiv     = 8;
  localparam int unsigned ClkDivWidth   = 4;
  localparam int unsigned BeatCntWidth  = $clog2(BeatsPerFrame);

  typedef logic [ClkDivWidth-1:0]  clk_div_t;
  typedef logic [BeatCntWidth-1:0] beat_cnt_t;

  localparam beat_cnt_t LastBeat = beat_cnt_t'(BeatsPerFrame - 1);

  // Header kind, steers the frame to one receive output
  typedef enum logic [FrameHdrWidth-1:0] {
    kind_narrow = 4'h1,
    kind_wide   = 4'h2
  } frame_kind_e;

  // Header in the top bits, narrow data zero-extended in the low bits
  // Beats leave least significant nibble first
  typedef struct packed {
    frame_kind_e          kind;
    logic [WideWidth-1:0] data;
  } frame_t;

endpackage

`default_nettype wire

// ==== logic/serial_link_reg_pkg.sv ====
// Register map of the link configuration block.
// Addresses and control bit positions, shared with the testbench.

`default_nettype none

package serial_link_reg_pkg;

  localparam int unsigned CfgDataWidth = 8;
  localparam int unsigned CtrlWidth    = 3;

  typedef enum logic [1:0] {
    addr_ctrl     = 2'd0,
    addr_clk_div  = 2'd1,
    addr_tx_count = 2'd2
  } cfg_addr_e;

  // Bits of the control register
  localparam int unsigned CtrlClkEnaBit    = 0;
  localparam int unsigned CtrlIsoNarrowBit = 1;
  localparam int unsigned CtrlIsoWideBit   = 2;

  localparam int unsigned ClkDivReset = 1;

endpackage

`default_nettype wire

// ==== logic/link_arbiter.sv ====
// Round-robin arbiter between the narrow and wide sources.
// Builds the link frame of the winner and hands it to the serializer.

`timescale 1ns/1ps
`default_nettype none

module link_arbiter (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_n_i,
  input  wire logic [serial_link_pkg::NarrowWidth-1:0] narrow_data_i,
  input  wire logic                                   narrow_valid_i,
  output logic                                        narrow_ready_o,
  input  wire logic [serial_link_pkg::WideWidth-1:0]   wide_data_i,
  input  wire logic                                   wide_valid_i,
  output logic                                        wide_ready_o,
  input  wire logic                                   iso_narrow_i,
  input  wire logic                                   iso_wide_i,
  output logic [serial_link_pkg::FrameWidth-1:0]      frame_o,
  output logic                                        frame_valid_o,
  input  wire logic                                   tx_ready_i
);

  logic narrow_req;
  logic wide_req;
  logic sel_wide;
  // High when the wide channel has priority
  logic rr_q;
  serial_link_pkg::frame_t frame;

  // Isolated channels never request
  assign narrow_req = narrow_valid_i & ~iso_narrow_i;
  assign wide_req   = wide_valid_i & ~iso_wide_i;

  // Wide wins on priority, or when narrow has nothing to send
  assign sel_wide = narrow_req ? (wide_req & rr_q) : (wide_req | rr_q);

  assign narrow_ready_o = tx_ready_i & ~iso_narrow_i & ~sel_wide;
  assign wide_ready_o   = tx_ready_i & ~iso_wide_i & sel_wide;
  assign frame_valid_o  = sel_wide ? wide_req : narrow_req;

  always_comb begin
    frame.data = '0;
    if (sel_wide) begin
      frame.kind = serial_link_pkg::kind_wide;
      frame.data = wide_data_i;
    end else begin
      frame.kind = serial_link_pkg::kind_narrow;
      frame.data[serial_link_pkg::NarrowWidth-1:0] = narrow_data_i;
    end
  end

  assign frame_o = frame;

  // Priority goes to the other channel after every grant
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q <= 1'b0;
    end else if (frame_valid_o && tx_ready_i) begin
      rr_q <= ~sel_wide;
    end
  end

  a_ready_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(narrow_ready_o && wide_ready_o));

endmodule

`default_nettype wire

// ==== logic/phy_tx.sv ====
// Transmit serializer of the physical layer.
// Sends one frame as nine beats of four lanes, each beat held for clk_div cycles.

`timescale 1ns/1ps
`default_nettype none

module phy_tx (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_n_i,
  input  wire logic [serial_link_pkg::FrameWidth-1:0] frame_i,
  input  wire logic                                 frame_valid_i,
  output logic                                      tx_ready_o,
  input  wire serial_link_pkg::clk_div_t            clk_div_i,
  output logic [serial_link_pkg::NumLanes-1:0]      lane_o,
  output logic                                      lane_valid_o,
  output logic                                      frame_sent_o
);

  typedef enum logic {
    tx_idle,
    tx_send
  } tx_state_e;

  tx_state_e                          state_q;
  logic [serial_link_pkg::FrameWidth-1:0] shift_q;
  serial_link_pkg::clk_div_t          div_cnt_q;
  serial_link_pkg::clk_div_t          div_eff;
  serial_link_pkg::beat_cnt_t         beat_cnt_q;
  logic                               beat_end;
  logic                               frame_sent_q;

  // Zero divider behaves like one
  assign div_eff  = (clk_div_i == '0) ? serial_link_pkg::clk_div_t'(1) : clk_div_i;
  assign beat_end = (div_cnt_q >= div_eff - 1'b1);

  assign tx_ready_o   = (state_q == tx_idle);
  assign lane_o       = shift_q[serial_link_pkg::NumLanes-1:0];
  assign lane_valid_o = (state_q == tx_send) && (div_cnt_q == '0);
  assign frame_sent_o = frame_sent_q;

  ////////////////////////////////////////////////////////////////////////////
  // Beat sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= tx_idle;
      div_cnt_q    <= '0;
      beat_cnt_q   <= '0;
      frame_sent_q <= 1'b0;
    end else begin
      frame_sent_q <= 1'b0;
      case (state_q)
        tx_idle: begin
          if (frame_valid_i) begin
            state_q    <= tx_send;
            div_cnt_q  <= '0;
            beat_cnt_q <= '0;
          end
        end
        tx_send: begin
          if (beat_end) begin
            div_cnt_q <= '0;
            if (beat_cnt_q == serial_link_pkg::LastBeat) begin
              state_q      <= tx_idle;
              frame_sent_q <= 1'b1;
            end else begin
              beat_cnt_q <= beat_cnt_q + 1'b1;
            end
          end else begin
            div_cnt_q <= div_cnt_q + 1'b1;
          end
        end
        default: state_q <= tx_idle;
      endcase
    end
  end

  // Frame shifts down one nibble at the end of every beat
  always_ff @(posedge clk_i) begin
    if (tx_ready_o && frame_valid_i) begin
      shift_q <= frame_i;
    end else if ((state_q == tx_send) && beat_end) begin
      shift_q <= shift_q >> serial_link_pkg::NumLanes;
    end
  end

  // At the last beat only the header nibble remains unless a frame was loaded mid-send
  a_no_accept_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ((state_q == tx_send) && (beat_cnt_q == serial_link_pkg::LastBeat)) |->
      ((shift_q >> serial_link_pkg::NumLanes) == '0));

endmodule

`default_nettype wire

// ==== logic/phy_rx.sv ====
// Receive deserializer of the physical layer.
// Collects nine lane beats and delivers the frame to the output its header names.

`timescale 1ns/1ps
`default_nettype none

module phy_rx (
  input  wire logic [serial_link_pkg::NumLanes-1:0] lane_i,
  input  wire logic                                lane_valid_i,
  input  wire logic                                clk_i,
  input  wire logic                                rst_n_i,
  output logic [serial_link_pkg::NarrowWidth-1:0]  narrow_data_o,
  output logic                                     narrow_valid_o,
  output logic [serial_link_pkg::WideWidth-1:0]    wide_data_o,
  output logic                                     wide_valid_o
);

  logic [serial_link_pkg::FrameWidth-1:0] shift_q;
  serial_link_pkg::beat_cnt_t             beat_cnt_q;
  logic                                   done_q;
  serial_link_pkg::frame_t                frame;

  // First beat ends up in the lowest nibble
  always_ff @(posedge clk_i) begin
    if (lane_valid_i) begin
      shift_q <= {lane_i, shift_q[serial_link_pkg::FrameWidth-1:serial_link_pkg::NumLanes]};
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      beat_cnt_q <= '0;
      done_q     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (lane_valid_i) begin
        if (beat_cnt_q == serial_link_pkg::LastBeat) begin
          beat_cnt_q <= '0;
          done_q     <= 1'b1;
        end else begin
          beat_cnt_q <= beat_cnt_q + 1'b1;
        end
      end
    end
  end

  // Unknown kinds are dropped
  assign frame          = serial_link_pkg::frame_t'(shift_q);
  assign narrow_valid_o = done_q && (frame.kind == serial_link_pkg::kind_narrow);
  assign wide_valid_o   = done_q && (frame.kind == serial_link_pkg::kind_wide);
  assign narrow_data_o  = frame.data[serial_link_pkg::NarrowWidth-1:0];
  assign wide_data_o    = frame.data;

  a_valid_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(narrow_valid_o && wide_valid_o));

endmodule

`default_nettype wire

// ==== logic/link_config_regs.sv ====
// Configuration and status registers of the link.
// Simple write port with combinational read, frame counter fed by the serializer.

`timescale 1ns/1ps
`default_nettype none

module link_config_regs (
  input  wire logic                                        clk_i,
  input  wire logic                                        rst_n_i,
  input  wire logic                                        cfg_we_i,
  input  wire logic [1:0]                                  cfg_addr_i,
  input  wire logic [serial_link_reg_pkg::CfgDataWidth-1:0] cfg_wdata_i,
  output logic [serial_link_reg_pkg::CfgDataWidth-1:0]     cfg_rdata_o,
  input  wire logic                                        frame_sent_i,
  output logic                                             clk_ena_o,
  output logic                                             iso_narrow_o,
  output logic                                             iso_wide_o,
  output serial_link_pkg::clk_div_t                        clk_div_o
);

  logic [serial_link_reg_pkg::CtrlWidth-1:0]    ctrl_q;
  serial_link_pkg::clk_div_t                    clk_div_q;
  logic [serial_link_reg_pkg::CfgDataWidth-1:0] tx_count_q;
  serial_link_reg_pkg::cfg_addr_e               addr;

  assign addr = serial_link_reg_pkg::cfg_addr_e'(cfg_addr_i);

  // Writes above the largest divider are clamped
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctrl_q    <= '0;
      clk_div_q <= serial_link_pkg::clk_div_t'(serial_link_reg_pkg::ClkDivReset);
    end else if (cfg_we_i) begin
      case (addr)
        serial_link_reg_pkg::addr_ctrl: begin
          ctrl_q <= cfg_wdata_i[serial_link_reg_pkg::CtrlWidth-1:0];
        end
        serial_link_reg_pkg::addr_clk_div: begin
          if (cfg_wdata_i > serial_link_pkg::MaxClkDiv) begin
            clk_div_q <= serial_link_pkg::clk_div_t'(serial_link_pkg::MaxClkDiv);
          end else begin
            clk_div_q <= cfg_wdata_i[serial_link_pkg::ClkDivWidth-1:0];
          end
        end
        default: ;
      endcase
    end
  end

  // Wraps at 256 frames
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_count_q <= '0;
    end else if (frame_sent_i) begin
      tx_count_q <= tx_count_q + 1'b1;
    end
  end

  always_comb begin
    cfg_rdata_o = '0;
    case (addr)
      serial_link_reg_pkg::addr_ctrl:     cfg_rdata_o[serial_link_reg_pkg::CtrlWidth-1:0] = ctrl_q;
      serial_link_reg_pkg::addr_clk_div:  cfg_rdata_o[serial_link_pkg::ClkDivWidth-1:0] = clk_div_q;
      serial_link_reg_pkg::addr_tx_count: cfg_rdata_o = tx_count_q;
      default:                            cfg_rdata_o = '0;
    endcase
  end

  assign clk_ena_o    = ctrl_q[serial_link_reg_pkg::CtrlClkEnaBit];
  assign iso_narrow_o = ctrl_q[serial_link_reg_pkg::CtrlIsoNarrowBit];
  assign iso_wide_o   = ctrl_q[serial_link_reg_pkg::CtrlIsoWideBit];
  assign clk_div_o    = clk_div_q;

  a_clk_div_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    clk_div_q <= serial_link_pkg::clk_div_t'(serial_link_pkg::MaxClkDiv));

endmodule

`default_nettype wire

// ==== logic/serial_link.sv ====
// Top level of the serial link.
// Two sources share the lanes through the arbiter, the receiver splits frames by kind.

`timescale 1ns/1ps
`default_nettype none

module serial_link (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_n_i,
  input  wire logic [serial_link_pkg::NarrowWidth-1:0] narrow_data_i,
  input  wire logic                                   narrow_valid_i,
  output logic                                        narrow_ready_o,
  input  wire logic [serial_link_pkg::WideWidth-1:0]   wide_data_i,
  input  wire logic                                   wide_valid_i,
  output logic                                        wide_ready_o,
  output logic [serial_link_pkg::NarrowWidth-1:0]     narrow_data_o,
  output logic                                        narrow_valid_o,
  output logic [serial_link_pkg::WideWidth-1:0]       wide_data_o,
  output logic                                        wide_valid_o,
  output logic [serial_link_pkg::NumLanes-1:0]        lane_o,
  output logic                                        lane_valid_o,
  input  wire logic [serial_link_pkg::NumLanes-1:0]    lane_i,
  input  wire logic                                   lane_valid_i,
  input  wire logic                                   cfg_we_i,
  input  wire logic [1:0]                             cfg_addr_i,
  input  wire logic [7:0]                             cfg_wdata_i,
  output logic [7:0]                                  cfg_rdata_o,
  output logic                                        clk_ena_o
);

  logic [serial_link_pkg::FrameWidth-1:0] frame;
  logic                                   frame_valid;
  logic                                   tx_ready;
  logic                                   frame_sent;
  logic                                   iso_narrow;
  logic                                   iso_wide;
  serial_link_pkg::clk_div_t              clk_div;

  ////////////////////////////////////////////////////////////////////////////
  // Transmit path
  ////////////////////////////////////////////////////////////////////////////

  link_arbiter i_link_arbiter (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .narrow_data_i  ( narrow_data_i  ),
    .narrow_valid_i ( narrow_valid_i ),
    .narrow_ready_o ( narrow_ready_o ),
    .wide_data_i    ( wide_data_i    ),
    .wide_valid_i   ( wide_valid_i   ),
    .wide_ready_o   ( wide_ready_o   ),
    .iso_narrow_i   ( iso_narrow     ),
    .iso_wide_i     ( iso_wide       ),
    .frame_o        ( frame          ),
    .frame_valid_o  ( frame_valid    ),
    .tx_ready_i     ( tx_ready       )
  );

  phy_tx i_phy_tx (
    .clk_i         ( clk_i        ),
    .rst_n_i       ( rst_n_i      ),
    .frame_i       ( frame        ),
    .frame_valid_i ( frame_valid  ),
    .tx_ready_o    ( tx_ready     ),
    .clk_div_i     ( clk_div      ),
    .lane_o        ( lane_o       ),
    .lane_valid_o  ( lane_valid_o ),
    .frame_sent_o  ( frame_sent   )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Receive path and registers
  ////////////////////////////////////////////////////////////////////////////

  phy_rx i_phy_rx (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .lane_i         ( lane_i         ),
    .lane_valid_i   ( lane_valid_i   ),
    .narrow_data_o  ( narrow_data_o  ),
    .narrow_valid_o ( narrow_valid_o ),
    .wide_data_o    ( wide_data_o    ),
    .wide_valid_o   ( wide_valid_o   )
  );

  link_config_regs i_link_config_regs (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .cfg_we_i     ( cfg_we_i    ),
    .cfg_addr_i   ( cfg_addr_i  ),
    .cfg_wdata_i  ( cfg_wdata_i ),
    .cfg_rdata_o  ( cfg_rdata_o ),
    .frame_sent_i ( frame_sent  ),
    .clk_ena_o    ( clk_ena_o   ),
    .iso_narrow_o ( iso_narrow  ),
    .iso_wide_o   ( iso_wide    ),
    .clk_div_o    ( clk_div     )
  );

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
// Free-running clock for the testbench, 40 ns period.
// Starts low at time zero.

`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// ==== tests/tb_serial_link.sv ====
// Testbench of the serial link with the lanes looped back onto the receiver.
// Random traffic on both channels is checked against one queue per channel.

`timescale 1ns/1ps
`default_nettype none

module tb_serial_link;

  // Longest run is about 200 frames at the largest divider
  localparam int TimeoutCycles =
    200 * serial_link_pkg::BeatsPerFrame * serial_link_pkg::MaxClkDiv + 4000;

  logic                                  clk_i;
  logic                                  rst_n_i;
  logic [serial_link_pkg::NarrowWidth-1:0] narrow_data_i;
  logic                                  narrow_valid_i;
  logic                                  narrow_ready_o;
  logic [serial_link_pkg::WideWidth-1:0] wide_data_i;
  logic                                  wide_valid_i;
  logic                                  wide_ready_o;
  logic [serial_link_pkg::NarrowWidth-1:0] narrow_data_o;
  logic                                  narrow_valid_o;
  logic [serial_link_pkg::WideWidth-1:0] wide_data_o;
  logic                                  wide_valid_o;
  logic [serial_link_pkg::NumLanes-1:0]  lane;
  logic                                  lane_valid;
  logic                                  cfg_we_i;
  logic [1:0]                            cfg_addr_i;
  logic [7:0]                            cfg_wdata_i;
  logic [7:0]                            cfg_rdata_o;
  logic                                  clk_ena_o;

  // Model and bookkeeping
  logic [serial_link_pkg::NarrowWidth-1:0] narrow_q[$];
  logic [serial_link_pkg::WideWidth-1:0]   wide_q[$];
  logic [serial_link_pkg::NarrowWidth-1:0] exp_narrow;
  logic [serial_link_pkg::WideWidth-1:0]   exp_wide;
  logic [31:0] rng_state = 32'h770b;
  int          cycle_cnt = 0;
  int          check_cnt = 0;
  int          err_cnt = 0;
  int          err_start = 0;
  int          xfer_cnt = 0;
  int          cur_div = 1;
  int          beat_idx = 0;
  int          last_lane_cyc = 0;
  logic        n_xfer;
  logic        w_xfer;
  logic        last_wide = 1'b0;
  logic        have_last = 1'b0;
  logic        rr_chk = 1'b0;
  logic        iso_chk = 1'b0;

  tb_clock clock_gen (
    .clk_o ( clk_i )
  );

  serial_link uut (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .narrow_data_i  ( narrow_data_i  ),
    .narrow_valid_i ( narrow_valid_i ),
    .narrow_ready_o ( narrow_ready_o ),
    .wide_data_i    ( wide_data_i    ),
    .wide_valid_i   ( wide_valid_i   ),
    .wide_ready_o   ( wide_ready_o   ),
    .narrow_data_o  ( narrow_data_o  ),
    .narrow_valid_o ( narrow_valid_o ),
    .wide_data_o    ( wide_data_o    ),
    .wide_valid_o   ( wide_valid_o   ),
    .lane_o         ( lane           ),
    .lane_valid_o   ( lane_valid     ),
    .lane_i         ( lane           ),
    .lane_valid_i   ( lane_valid     ),
    .cfg_we_i       ( cfg_we_i       ),
    .cfg_addr_i     ( cfg_addr_i     ),
    .cfg_wdata_i    ( cfg_wdata_i    ),
    .cfg_rdata_o    ( cfg_rdata_o    ),
    .clk_ena_o      ( clk_ena_o      )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // xorshift32
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic write_cfg(input logic [1:0] addr, input logic [7:0] data);
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    cfg_we_i    = 1'b1;
    @(posedge clk_i);
    #2;
    cfg_we_i = 1'b0;
  endtask

  task automatic read_cfg(input logic [1:0] addr, output logic [7:0] data);
    cfg_addr_i = addr;
    @(negedge clk_i);
    data = cfg_rdata_o;
    @(posedge clk_i);
    #2;
  endtask

  // Values above the largest divider are clamped by the register block
  task automatic set_div(input int val);
    write_cfg(serial_link_reg_pkg::addr_clk_div, 8'(val));
    cur_div = (val > int'(serial_link_pkg::MaxClkDiv)) ? int'(serial_link_pkg::MaxClkDiv) : val;
  endtask

  task automatic send_narrow(input int count, input int max_gap);
    logic [31:0] r;
    logic        hs;
    for (int i = 0; i < count; i++) begin
      narrow_valid_i = 1'b0;
      repeat (int'(next_rand() % 32'(max_gap + 1))) begin
        @(posedge clk_i);
        #2;
      end
      r = next_rand();
      narrow_data_i  = r[serial_link_pkg::NarrowWidth-1:0];
      narrow_valid_i = 1'b1;
      hs = 1'b0;
      while (!hs) begin
        @(negedge clk_i);
        hs = narrow_ready_o;
        @(posedge clk_i);
        #2;
      end
    end
    narrow_valid_i = 1'b0;
  endtask

  task automatic send_wide(input int count, input int max_gap);
    logic hs;
    for (int i = 0; i < count; i++) begin
      wide_valid_i = 1'b0;
      repeat (int'(next_rand() % 32'(max_gap + 1))) begin
        @(posedge clk_i);
        #2;
      end
      wide_data_i  = next_rand();
      wide_valid_i = 1'b1;
      hs = 1'b0;
      while (!hs) begin
        @(negedge clk_i);
        hs = wide_ready_o;
        @(posedge clk_i);
        #2;
      end
    end
    wide_valid_i = 1'b0;
  endtask

  // Serializer idle and every word delivered
  task automatic wait_drained();
    logic idle;
    idle = 1'b0;
    while (!idle) begin
      @(negedge clk_i);
      idle = (narrow_q.size() == 0) && (wide_q.size() == 0) &&
             (narrow_ready_o || wide_ready_o);
      @(posedge clk_i);
      #2;
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %s done with %0d errors", name, err_cnt - err_start);
    err_start = err_cnt;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitor and reference model
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  always @(negedge clk_i) begin
    if (rst_n_i) begin
      n_xfer = narrow_valid_i && narrow_ready_o;
      w_xfer = wide_valid_i && wide_ready_o;
      if (n_xfer) narrow_q.push_back(narrow_data_i);
      if (w_xfer) wide_q.push_back(wide_data_i);
      if (n_xfer || w_xfer) begin
        // With both channels requesting, the grant goes to the other channel
        if (rr_chk && have_last && narrow_valid_i && wide_valid_i) begin
          check_value("grant_wide", 32'(w_xfer), 32'(!last_wide));
        end
        last_wide = w_xfer;
        have_last = 1'b1;
        xfer_cnt++;
      end
      if (narrow_valid_o) begin
        if (narrow_q.size() == 0) begin
          err_cnt++;
          $display("Error at %0t: narrow word received while none was pending", $time);
        end else begin
          exp_narrow = narrow_q.pop_front();
          check_value("narrow_data_o", 32'(narrow_data_o), 32'(exp_narrow));
        end
      end
      if (wide_valid_o) begin
        if (wide_q.size() == 0) begin
          err_cnt++;
          $display("Error at %0t: wide word received while none was pending", $time);
        end else begin
          exp_wide = wide_q.pop_front();
          check_value("wide_data_o", wide_data_o, exp_wide);
        end
      end
      // Beats inside one frame are spaced by the divider
      if (lane_valid) begin
        if (beat_idx != 0) begin
          check_value("lane_valid_o spacing", 32'(cycle_cnt - last_lane_cyc), 32'(cur_div));
        end
        last_lane_cyc = cycle_cnt;
        beat_idx = (beat_idx == int'(serial_link_pkg::BeatsPerFrame) - 1) ? 0 : beat_idx + 1;
      end
      if (iso_chk) check_value("narrow_ready_o", 32'(narrow_ready_o), 32'd0);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [7:0] rd;
    narrow_data_i  = '0;
    narrow_valid_i = 1'b0;
    wide_data_i    = '0;
    wide_valid_i   = 1'b0;
    cfg_we_i       = 1'b0;
    cfg_addr_i     = '0;
    cfg_wdata_i    = '0;
    rst_n_i        = 1'b0;
    repeat (5) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;

    set_div(int'(next_rand() % 32'd8) + 1);
    send_narrow(40, 3);
    wait_drained();
    finish_test("narrow traffic");

    set_div(int'(next_rand() % 32'd8) + 1);
    send_wide(40, 3);
    wait_drained();
    finish_test("wide traffic");

    set_div(2);
    rr_chk = 1'b1;
    fork
      send_narrow(30, 0);
      send_wide(30, 0);
    join
    rr_chk = 1'b0;
    wait_drained();
    finish_test("shared link");

    set_div(1);
    write_cfg(serial_link_reg_pkg::addr_ctrl, 8'(1 << serial_link_reg_pkg::CtrlIsoNarrowBit));
    iso_chk = 1'b1;
    fork
      send_narrow(10, 0);
      begin
        send_wide(10, 1);
        iso_chk = 1'b0;
        write_cfg(serial_link_reg_pkg::addr_ctrl, 8'd0);
      end
    join
    wait_drained();
    finish_test("isolation");

    write_cfg(serial_link_reg_pkg::addr_ctrl, 8'(1 << serial_link_reg_pkg::CtrlClkEnaBit));
    read_cfg(serial_link_reg_pkg::addr_ctrl, rd);
    check_value("ctrl", 32'(rd), 32'(1 << serial_link_reg_pkg::CtrlClkEnaBit));
    check_value("clk_ena_o", 32'(clk_ena_o), 32'd1);
    write_cfg(serial_link_reg_pkg::addr_ctrl, 8'd0);
    read_cfg(serial_link_reg_pkg::addr_ctrl, rd);
    check_value("ctrl", 32'(rd), 32'd0);
    check_value("clk_ena_o", 32'(clk_ena_o), 32'd0);
    set_div(5);
    read_cfg(serial_link_reg_pkg::addr_clk_div, rd);
    check_value("clk_div", 32'(rd), 32'd5);
    set_div(12);
    read_cfg(serial_link_reg_pkg::addr_clk_div, rd);
    check_value("clk_div", 32'(rd), 32'(serial_link_pkg::MaxClkDiv));
    send_narrow(4, 0);
    wait_drained();
    read_cfg(serial_link_reg_pkg::addr_tx_count, rd);
    check_value("tx_count", 32'(rd), 32'(xfer_cnt % 256));
    finish_test("registers");

    $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/serial_link_pkg.sv
logic/serial_link_reg_pkg.sv
logic/link_arbiter.sv
logic/phy_tx.sv
logic/phy_rx.sv
logic/link_config_regs.sv
logic/serial_link.sv
tests/tb_clock.sv
tests/tb_serial_link.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the serial link testbench, result taken from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_serial_link -f sim.f > sim.log 2>&1 \
  && ./obj_dir/Vtb_serial_link >> sim.log 2>&1 \
  || echo "STATUS: FAIL" >> sim.log
cat sim.log
if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
exit 0
